// File: rtl/yolo_write_defs.svh
`ifndef YOLO_WRITE_DEFS_SVH
`define YOLO_WRITE_DEFS_SVH

// processing stages fed by one descriptor stream
`define YW_NSTAGES 4

// external address and distance between stage bases
`define YW_IO_ADDR_W 32
`define YW_OFFSET_W 16

// internal buffer address, also the loop count width
// msb of the internal address is the ping-pong bank
`define YW_PIXEL_ADDR_W 10

// configuration register map
`define YW_CONF_ADDR_W 4

`define YW_CONF_EXT_ADDR 0
`define YW_CONF_OFFSET 1
// nonzero enables ping-pong
`define YW_CONF_EXT_ITER 2
`define YW_CONF_START 3
`define YW_CONF_ITER 4
`define YW_CONF_PER 5
`define YW_CONF_SHIFT 6
`define YW_CONF_INCR 7

`endif

// File: rtl/yolo_write_pkg.sv
`include "yolo_write_defs.svh"

package yolo_write_pkg;

   // external memory address
   typedef logic [`YW_IO_ADDR_W-1:0] io_addr_t;

   // distance between two stage bases
   typedef logic [`YW_OFFSET_W-1:0] offset_t;

   // internal buffer address or loop count
   typedef logic [`YW_PIXEL_ADDR_W-1:0] pixel_addr_t;

   typedef logic [$clog2(`YW_NSTAGES)-1:0] stage_idx_t;

   typedef logic [`YW_CONF_ADDR_W-1:0] conf_addr_t;

   // descriptor sequencer
   typedef enum logic [2:0] {
      ST_IDLE,
      ST_CALC,
      ST_ISSUE,
      ST_WAIT_ACK_HIGH,
      ST_WAIT_ACK_LOW
   } write_state_t;

endpackage

// File: rtl/conf_regs.sv
`timescale 1ns/10ps

`include "yolo_write_defs.svh"

module conf_regs import yolo_write_pkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  logic        clear,
   input  logic        valid,
   input  logic        wstrb,
   input  conf_addr_t  addr,
   input  io_addr_t    wdata,
   input  logic        load,
   output io_addr_t    ext_base,
   output offset_t     offset,
   output pixel_addr_t start,
   output pixel_addr_t iter,
   output pixel_addr_t per,
   output pixel_addr_t shift,
   output pixel_addr_t incr,
   output logic        bank
);

   // working copy written by the cpu
   io_addr_t    ext_base_w;
   offset_t     offset_w;
   pixel_addr_t ext_iter_w;
   pixel_addr_t start_w;
   pixel_addr_t iter_w;
   pixel_addr_t per_w;
   pixel_addr_t shift_w;
   pixel_addr_t incr_w;

   logic        wr_en;

   assign wr_en = valid && wstrb;

   // clear wipes the working copy only
   always_ff @(posedge clk, posedge rst, posedge clear) begin
      if (rst || clear) begin
         ext_base_w <= '0;
         offset_w   <= '0;
         ext_iter_w <= '0;
         start_w    <= '0;
         iter_w     <= '0;
         per_w      <= '0;
         shift_w    <= '0;
         incr_w     <= '0;
      end else if (wr_en) begin
         case (addr)
            conf_addr_t'(`YW_CONF_EXT_ADDR): begin
               ext_base_w <= wdata;
            end
            conf_addr_t'(`YW_CONF_OFFSET): begin
               offset_w <= wdata[`YW_OFFSET_W-1:0];
            end
            conf_addr_t'(`YW_CONF_EXT_ITER): begin
               ext_iter_w <= wdata[`YW_PIXEL_ADDR_W-1:0];
            end
            conf_addr_t'(`YW_CONF_START): begin
               start_w <= wdata[`YW_PIXEL_ADDR_W-1:0];
            end
            conf_addr_t'(`YW_CONF_ITER): begin
               iter_w <= wdata[`YW_PIXEL_ADDR_W-1:0];
            end
            conf_addr_t'(`YW_CONF_PER): begin
               per_w <= wdata[`YW_PIXEL_ADDR_W-1:0];
            end
            conf_addr_t'(`YW_CONF_SHIFT): begin
               shift_w <= wdata[`YW_PIXEL_ADDR_W-1:0];
            end
            conf_addr_t'(`YW_CONF_INCR): begin
               incr_w <= wdata[`YW_PIXEL_ADDR_W-1:0];
            end
            default: begin
            end
         endcase
      end
   end

   // shadow copy, frozen for the whole run
   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         ext_base <= '0;
         offset   <= '0;
         start    <= '0;
         iter     <= '0;
         per      <= '0;
         shift    <= '0;
         incr     <= '0;
      end else if (load) begin
         ext_base <= ext_base_w;
         offset   <= offset_w;
         start    <= start_w;
         iter     <= iter_w;
         per      <= per_w;
         shift    <= shift_w;
         incr     <= incr_w;
      end
   end

   // ping-pong only when external transfers are on
   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         bank <= 1'b0;
      end else if (load) begin
         bank <= bank ^ (|ext_iter_w);
      end
   end

endmodule

// File: rtl/stage_addr_calc.sv
`timescale 1ns/10ps

`include "yolo_write_defs.svh"

module stage_addr_calc import yolo_write_pkg::*; (
   input  logic       clk,
   input  logic       rst,
   input  logic       start_calc,
   input  io_addr_t   ext_base,
   input  offset_t    offset,
   input  stage_idx_t stage,
   output io_addr_t   stage_addr,
   output logic       stages_valid
);

   io_addr_t   base_tbl [`YW_NSTAGES];
   io_addr_t   acc;
   io_addr_t   sum;
   stage_idx_t idx;
   logic       busy;

   // single adder, seeded from the base on start
   assign sum = (start_calc ? ext_base : acc) + io_addr_t'(offset);

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         idx          <= '0;
         busy         <= 1'b0;
         stages_valid <= 1'b0;
      end else if (start_calc) begin
         idx          <= stage_idx_t'(2);
         busy         <= 1'b1;
         stages_valid <= 1'b0;
      end else if (busy) begin
         idx <= idx + 1'b1;
         if (idx == stage_idx_t'(`YW_NSTAGES - 1)) begin
            busy         <= 1'b0;
            stages_valid <= 1'b1;
         end
      end
   end

   // stage 0 and 1 land together on start
   always_ff @(posedge clk) begin
      if (start_calc) begin
         base_tbl[0] <= ext_base;
         base_tbl[1] <= sum;
         acc         <= sum;
      end else if (busy) begin
         base_tbl[idx] <= sum;
         acc           <= sum;
      end
   end

   assign stage_addr = base_tbl[stage];

endmodule

// File: rtl/write_addr_gen.sv
`timescale 1ns/10ps

module write_addr_gen import yolo_write_pkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  logic        init,
   input  logic        step,
   input  pixel_addr_t start,
   input  pixel_addr_t iter,
   input  pixel_addr_t per,
   input  pixel_addr_t shift,
   input  pixel_addr_t incr,
   output pixel_addr_t addr,
   output logic        last,
   output logic        empty
);

   // inner runs over one period, outer over iterations
   pixel_addr_t k_cnt;
   pixel_addr_t j_cnt;
   pixel_addr_t per_base;
   logic        per_end;

   assign per_end = (k_cnt == per - 1'b1);

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         k_cnt <= '0;
         j_cnt <= '0;
      end else if (init) begin
         k_cnt <= '0;
         j_cnt <= '0;
      end else if (step) begin
         if (per_end) begin
            k_cnt <= '0;
            j_cnt <= j_cnt + 1'b1;
         end else begin
            k_cnt <= k_cnt + 1'b1;
         end
      end
   end

   // address path, wraps modulo the buffer size
   always_ff @(posedge clk) begin
      if (init) begin
         per_base <= start;
         addr     <= start;
      end else if (step) begin
         if (per_end) begin
            per_base <= per_base + shift;
            addr     <= per_base + shift;
         end else begin
            addr <= addr + incr;
         end
      end
   end

   assign last  = per_end && (j_cnt == iter - 1'b1);
   assign empty = (iter == '0) || (per == '0);

endmodule

// File: rtl/write_ctrl.sv
`timescale 1ns/10ps

`include "yolo_write_defs.svh"

module write_ctrl import yolo_write_pkg::*; (
   input  logic       clk,
   input  logic       rst,
   input  logic       run,
   input  logic       stages_valid,
   input  logic       gen_last,
   input  logic       gen_empty,
   input  logic       ack,
   output logic       load,
   output logic       start_calc,
   output logic       gen_init,
   output logic       gen_step,
   output stage_idx_t stage,
   output logic       req,
   output logic       done
);

   write_state_t state;
   logic         init_pulse;
   logic         last_stage;

   assign last_stage = (stage == stage_idx_t'(`YW_NSTAGES - 1));

   // run only counts while idle
   assign load = run && (state == ST_IDLE);
   assign done = (state == ST_IDLE);

   // shadow values are valid one cycle after load
   assign start_calc = init_pulse;
   assign gen_init   = init_pulse;

   // next address once all stages saw the current one
   assign gen_step = (state == ST_WAIT_ACK_LOW) && !ack && last_stage && !gen_last;

   always_ff @(posedge clk, posedge rst) begin
      if (rst) begin
         state      <= ST_IDLE;
         init_pulse <= 1'b0;
         stage      <= '0;
         req        <= 1'b0;
      end else begin
         init_pulse <= load;
         case (state)
            ST_IDLE: begin
               if (load) begin
                  stage <= '0;
                  state <= ST_CALC;
               end
            end
            ST_CALC: begin
               // stale valid from the last run is ignored
               if (stages_valid && !init_pulse) begin
                  state <= gen_empty ? ST_IDLE : ST_ISSUE;
               end
            end
            ST_ISSUE: begin
               req   <= 1'b1;
               state <= ST_WAIT_ACK_HIGH;
            end
            ST_WAIT_ACK_HIGH: begin
               if (ack) begin
                  req   <= 1'b0;
                  state <= ST_WAIT_ACK_LOW;
               end
            end
            ST_WAIT_ACK_LOW: begin
               if (!ack) begin
                  if (!last_stage) begin
                     stage <= stage + 1'b1;
                     state <= ST_ISSUE;
                  end else if (gen_last) begin
                     state <= ST_IDLE;
                  end else begin
                     stage <= '0;
                     state <= ST_ISSUE;
                  end
               end
            end
            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

endmodule

// File: rtl/yolo_write_top.sv
`timescale 1ns/10ps

`include "yolo_write_defs.svh"

module yolo_write_top import yolo_write_pkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  logic        clear,
   input  logic        run,
   input  logic        valid,
   input  logic        wstrb,
   input  conf_addr_t  addr,
   input  io_addr_t    wdata,
   input  logic        ack,
   output logic        done,
   output logic        req,
   output stage_idx_t  stage,
   output io_addr_t    ext_addr,
   output pixel_addr_t int_addr
);

   io_addr_t    ext_base;
   offset_t     offset;
   pixel_addr_t start;
   pixel_addr_t iter;
   pixel_addr_t per;
   pixel_addr_t shift;
   pixel_addr_t incr;
   logic        bank;

   logic        load;
   logic        start_calc;
   logic        stages_valid;
   logic        gen_init;
   logic        gen_step;
   logic        gen_last;
   logic        gen_empty;
   pixel_addr_t gen_addr;

   conf_regs conf_regs_i (
      .clk      (clk),
      .rst      (rst),
      .clear    (clear),
      .valid    (valid),
      .wstrb    (wstrb),
      .addr     (addr),
      .wdata    (wdata),
      .load     (load),
      .ext_base (ext_base),
      .offset   (offset),
      .start    (start),
      .iter     (iter),
      .per      (per),
      .shift    (shift),
      .incr     (incr),
      .bank     (bank)
   );

   stage_addr_calc stage_addr_calc_i (
      .clk          (clk),
      .rst          (rst),
      .start_calc   (start_calc),
      .ext_base     (ext_base),
      .offset       (offset),
      .stage        (stage),
      .stage_addr   (ext_addr),
      .stages_valid (stages_valid)
   );

   write_addr_gen write_addr_gen_i (
      .clk   (clk),
      .rst   (rst),
      .init  (gen_init),
      .step  (gen_step),
      .start (start),
      .iter  (iter),
      .per   (per),
      .shift (shift),
      .incr  (incr),
      .addr  (gen_addr),
      .last  (gen_last),
      .empty (gen_empty)
   );

   write_ctrl write_ctrl_i (
      .clk          (clk),
      .rst          (rst),
      .run          (run),
      .stages_valid (stages_valid),
      .gen_last     (gen_last),
      .gen_empty    (gen_empty),
      .ack          (ack),
      .load         (load),
      .start_calc   (start_calc),
      .gen_init     (gen_init),
      .gen_step     (gen_step),
      .stage        (stage),
      .req          (req),
      .done         (done)
   );

   // bank bit replaces the generator msb
   assign int_addr = {bank, gen_addr[`YW_PIXEL_ADDR_W-2:0]};

endmodule

// File: bench/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
   parameter real PERIOD = 100.0
) (
   output logic clk
);

   initial clk = 1'b0;

   always #(PERIOD / 2.0) clk = ~clk;

endmodule

// File: bench/yolo_write_assertions.sv
`timescale 1ns/10ps

module yolo_write_assertions import yolo_write_pkg::*; (
   input logic        clk,
   input logic        rst,
   input logic        req,
   input logic        ack,
   input stage_idx_t  stage,
   input io_addr_t    ext_addr,
   input pixel_addr_t int_addr
);

   req_low_in_reset: assert property (@(posedge clk) rst |-> !req)
      else $error("req high while in reset");

   // descriptor fields frozen until req drops
   data_stable: assert property (@(posedge clk) disable iff (rst)
      req && $past(req) |-> $stable({stage, ext_addr, int_addr}))
      else $error("descriptor changed while req was high");

   // four-phase, next req only after ack low
   req_waits_ack_low: assert property (@(posedge clk) disable iff (rst)
      !req && ack |=> !req)
      else $error("req rose while ack was still high");

endmodule

bind yolo_write_top yolo_write_assertions yolo_write_assertions_i (.*);

// File: bench/tb_yolo_write.sv
`timescale 1ns/10ps

`include "yolo_write_defs.svh"

module tb_yolo_write import yolo_write_pkg::*; ();

   logic        clk;
   logic        rst;
   logic        clear;
   logic        run;
   logic        valid;
   logic        wstrb;
   conf_addr_t  addr;
   io_addr_t    wdata;
   logic        ack;
   logic        done;
   logic        req;
   stage_idx_t  stage;
   io_addr_t    ext_addr;
   pixel_addr_t int_addr;

   // cpu view of the register map and the descriptors still due
   io_addr_t    cfg [8];
   logic [43:0] exp_q [$];
   logic        exp_bank;
   logic        req_q;
   int unsigned seed;

   tb_clock_gen clk_gen_i (.clk(clk));

   yolo_write_top dut_i (.*);

   function automatic int unsigned lcg_next();
      seed = seed * 32'd1103515245 + 32'd12345;
      return seed >> 16;
   endfunction

   // stage, external address and internal address of one descriptor
   function automatic logic [43:0] ref_desc(input int j, input int k, input int s);
      io_addr_t    ext;
      pixel_addr_t int_a;
      ext = cfg[`YW_CONF_EXT_ADDR]
         + io_addr_t'(s) * io_addr_t'(offset_t'(cfg[`YW_CONF_OFFSET]));
      int_a = pixel_addr_t'(cfg[`YW_CONF_START])
         + pixel_addr_t'(j) * pixel_addr_t'(cfg[`YW_CONF_SHIFT])
         + pixel_addr_t'(k) * pixel_addr_t'(cfg[`YW_CONF_INCR]);
      int_a[`YW_PIXEL_ADDR_W-1] = exp_bank;
      return {stage_idx_t'(s), ext, int_a};
   endfunction

   task automatic fail_now(input string why);
      $display("%s", why);
      $display("Simulation failed");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         fail_now($sformatf("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp));
      end
   endtask

   task automatic write_field(input conf_addr_t a, input io_addr_t d);
      @(negedge clk);
      valid = 1'b1;
      wstrb = 1'b1;
      addr  = a;
      wdata = d;
      @(negedge clk);
      valid = 1'b0;
      wstrb = 1'b0;
   endtask

   task automatic set_config(input bit pp);
      int i;
      for (i = 0; i < 8; i++) begin
         cfg[i] = (lcg_next() << 16) ^ lcg_next();
      end
      // small loop counts under random upper bits
      cfg[`YW_CONF_ITER] = (cfg[`YW_CONF_ITER] & ~32'h3ff) | (1 + lcg_next() % 3);
      cfg[`YW_CONF_PER]  = (cfg[`YW_CONF_PER] & ~32'h3ff) | (1 + lcg_next() % 3);
      cfg[`YW_CONF_EXT_ITER] = (cfg[`YW_CONF_EXT_ITER] & ~32'h3ff) | (pp ? 32'h2a : 32'h0);
      for (i = 0; i < 8; i++) begin
         write_field(conf_addr_t'(i), cfg[i]);
      end
      // unmapped index
      write_field(conf_addr_t'(12), 32'hffff_ffff);
   endtask

   task automatic do_run(input bit writes_during_run);
      int j;
      int k;
      int s;
      int n;
      if (pixel_addr_t'(cfg[`YW_CONF_EXT_ITER]) != '0) begin
         exp_bank = ~exp_bank;
      end
      for (j = 0; j < pixel_addr_t'(cfg[`YW_CONF_ITER]); j++) begin
         for (k = 0; k < pixel_addr_t'(cfg[`YW_CONF_PER]); k++) begin
            for (s = 0; s < `YW_NSTAGES; s++) begin
               exp_q.push_back(ref_desc(j, k, s));
            end
         end
      end
      @(negedge clk);
      run = 1'b1;
      @(negedge clk);
      run = 1'b0;
      if (writes_during_run) begin
         set_config(1'b1);
      end
      // ack each descriptor after a random delay until done
      forever begin
         n = 0;
         while (!req && !done) begin
            @(negedge clk);
            n++;
            if (n > 100) fail_now("timeout waiting for a descriptor or for done");
         end
         if (done) break;
         repeat (lcg_next() % 4) @(negedge clk);
         ack = 1'b1;
         n = 0;
         while (req) begin
            @(negedge clk);
            n++;
            if (n > 10) fail_now("timeout waiting for req to fall after ack");
         end
         ack = 1'b0;
      end
      check_val("descriptors_left", exp_q.size(), 0);
   endtask

   // outputs settle after the rising edge
   always @(negedge clk) begin
      logic [43:0] exp_d;
      if (req && !req_q) begin
         if (exp_q.size() == 0) begin
            fail_now("descriptor issued beyond the expected list");
         end else begin
            exp_d = exp_q.pop_front();
            check_val("stage", stage, exp_d[43:42]);
            check_val("ext_addr", ext_addr, exp_d[41:10]);
            check_val("int_addr", int_addr, exp_d[9:0]);
         end
      end
      req_q = req;
   end

   initial begin
      seed     = 37;
      exp_bank = 1'b0;
      req_q    = 1'b0;
      rst      = 1'b1;
      clear    = 1'b0;
      run      = 1'b0;
      valid    = 1'b0;
      wstrb    = 1'b0;
      addr     = '0;
      wdata    = '0;
      ack      = 1'b0;
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      check_val("done", done, 1);
      check_val("req", req, 0);
      // three ping-pong runs give bank 1 then 0 then 1
      repeat (3) begin
         set_config(1'b1);
         do_run(1'b0);
      end
      // bank holds here and writes made during this run belong to the next one
      set_config(1'b0);
      do_run(1'b1);
      do_run(1'b0);
      @(negedge clk);
      clear = 1'b1;
      @(negedge clk);
      clear = 1'b0;
      cfg = '{default: '0};
      do_run(1'b0);
      $display("Simulation passed");
      $finish;
   end

endmodule

// File: all.f
+incdir+rtl
rtl/yolo_write_pkg.sv
rtl/conf_regs.sv
rtl/stage_addr_calc.sv
rtl/write_addr_gen.sv
rtl/write_ctrl.sv
rtl/yolo_write_top.sv
bench/tb_clock_gen.sv
bench/yolo_write_assertions.sv
bench/tb_yolo_write.sv
